// File: verilog.f
hw/axil_xbar_pkg.sv
hw/axil_addr_decode.sv
hw/axil_write_router.sv
hw/axil_read_router.sv
hw/axil_reg_bank.sv
hw/axil_xbar_top.sv
verif/axil_clk_gen.sv
verif/axil_xbar_tb.sv

// File: Bender.yml
package:
  name: axil_xbar

sources:
  - files:
      - hw/axil_xbar_pkg.sv
      - hw/axil_addr_decode.sv
      - hw/axil_write_router.sv
      - hw/axil_read_router.sv
      - hw/axil_reg_bank.sv
      - hw/axil_xbar_top.sv
  - target: test
    files:
      - verif/axil_clk_gen.sv
      - verif/axil_xbar_tb.sv

// File: verif/axil_xbar_tb.sv
`timescale 1ns/1ps

module axil_xbar_tb
    import axil_xbar_pkg::*;
();

    localparam int NUM_MGRS     = 2;
    localparam int NUM_SUBS     = 2;
    localparam int BANK_WORDS   = 256;
    localparam int RESET_CYCLES = 10;
    localparam int MIX_OPS      = 300;
    localparam int NUM_TRANS    = 16 + 4 + 6 + NUM_MGRS * MIX_OPS + NUM_SUBS * BANK_WORDS;
    localparam int LIMIT_CYCLES = RESET_CYCLES + 200 * NUM_TRANS;

    logic                 seq;
    logic                 reset;
    logic  [NUM_MGRS-1:0] awvalid;
    logic  [NUM_MGRS-1:0] awready;
    addr_t [NUM_MGRS-1:0] awaddr;
    logic  [NUM_MGRS-1:0] wvalid;
    logic  [NUM_MGRS-1:0] wready;
    data_t [NUM_MGRS-1:0] wdata;
    strb_t [NUM_MGRS-1:0] wstrb;
    logic  [NUM_MGRS-1:0] bvalid;
    logic  [NUM_MGRS-1:0] bready;
    resp_t [NUM_MGRS-1:0] bresp;
    logic  [NUM_MGRS-1:0] arvalid;
    logic  [NUM_MGRS-1:0] arready;
    addr_t [NUM_MGRS-1:0] araddr;
    logic  [NUM_MGRS-1:0] rvalid;
    logic  [NUM_MGRS-1:0] rready;
    data_t [NUM_MGRS-1:0] rdata;
    resp_t [NUM_MGRS-1:0] rresp;

    data_t shadow [NUM_SUBS][BANK_WORDS];
    string cmp_name [$];
    data_t cmp_exp [$];
    data_t cmp_act [$];
    int    checks      = 0;
    int    errors      = 0;
    int    test_checks = 0;
    int    test_errors = 0;

    axil_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_gen_i (
        .seq   (seq),
        .reset (reset)
    );

    axil_xbar_top #(
        .NUM_MGRS   (NUM_MGRS),
        .NUM_SUBS   (NUM_SUBS),
        .BANK_WORDS (BANK_WORDS)
    ) axil_xbar_top_i (
        .seq     (seq),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    function automatic addr_t word_addr(int sub, int word);
        return (addr_t'(sub) << REGION_LSB) | addr_t'(word * 4);
    endfunction

    // Word index whose low bit is m, so two managers never share a word.
    function automatic int own_word(int m);
        return 2 * int'($urandom_range(BANK_WORDS / 2 - 1, 0)) + m;
    endfunction

    function automatic resp_t expect_resp(addr_t a);
        return ((a >> REGION_LSB) < NUM_SUBS) ? RESP_OKAY : RESP_DECERR;
    endfunction

    function automatic data_t expect_read(addr_t a);
        int region;
        region = int'(a >> REGION_LSB);
        if (region >= NUM_SUBS) begin
            return '0; // Unmapped reads carry zero data.
        end
        return shadow[region][(a >> 2) % BANK_WORDS];
    endfunction

    function automatic data_t merge_bytes(data_t old, data_t d, strb_t s);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                res[8*b +: 8] = d[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic void model_write(addr_t a, data_t d, strb_t s);
        int region;
        int word;
        region = int'(a >> REGION_LSB);
        word   = int'((a >> 2) % BANK_WORDS);
        if (region < NUM_SUBS) begin
            shadow[region][word] = merge_bytes(shadow[region][word], d, s);
        end
    endfunction

    task automatic post_check(string name, data_t exp, data_t act);
        cmp_name.push_back(name);
        cmp_exp.push_back(exp);
        cmp_act.push_back(act);
    endtask

    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge seq);
            #1;
        end
    endtask

    task automatic write_txn(int m, string name, addr_t a, data_t d, strb_t s, int max_stall);
        bit    aw_done;
        bit    w_done;
        bit    aw_hs;
        bit    w_hs;
        bit    b_hs;
        resp_t resp;
        aw_done    = 1'b0;
        w_done     = 1'b0;
        awaddr[m]  = a;
        awvalid[m] = 1'b1;
        wdata[m]   = d;
        wstrb[m]   = s;
        wvalid[m]  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge seq);
            aw_hs = awvalid[m] && awready[m];
            w_hs  = wvalid[m] && wready[m];
            @(posedge seq);
            #1;
            if (aw_hs) begin
                aw_done    = 1'b1;
                awvalid[m] = 1'b0;
            end
            if (w_hs) begin
                w_done    = 1'b1;
                wvalid[m] = 1'b0;
            end
        end
        wait_cycles($urandom_range(max_stall, 0));
        bready[m] = 1'b1;
        do begin
            @(negedge seq);
            b_hs = bvalid[m];
            resp = bresp[m];
            @(posedge seq);
            #1;
        end while (!b_hs);
        bready[m] = 1'b0;
        post_check({name, " bresp"}, expect_resp(a), resp);
        model_write(a, d, s);
    endtask

    task automatic read_txn(int m, string name, addr_t a, int max_stall);
        bit    ar_hs;
        bit    r_hs;
        data_t data;
        resp_t resp;
        araddr[m]  = a;
        arvalid[m] = 1'b1;
        do begin
            @(negedge seq);
            ar_hs = arready[m];
            @(posedge seq);
            #1;
        end while (!ar_hs);
        arvalid[m] = 1'b0;
        wait_cycles($urandom_range(max_stall, 0));
        rready[m] = 1'b1;
        do begin
            @(negedge seq);
            r_hs = rvalid[m];
            data = rdata[m];
            resp = rresp[m];
            @(posedge seq);
            #1;
        end while (!r_hs);
        rready[m] = 1'b0;
        post_check({name, " rdata"}, expect_read(a), data);
        post_check({name, " rresp"}, expect_resp(a), resp);
    endtask

    task automatic run_mix(int m);
        addr_t a;
        string name;
        for (int i = 0; i < MIX_OPS; i++) begin
            a    = word_addr(1, own_word(m)); // Both managers share bank 1.
            name = $sformatf("mix m%0d op%0d", m, i);
            if ($urandom_range(1, 0) == 1) begin
                write_txn(m, name, a, $urandom, strb_t'($urandom), 3);
            end else begin
                read_txn(m, name, a, 3);
            end
        end
    endtask

    task automatic finish_test(string name);
        wait (cmp_act.size() == 0);
        $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        string name;
        data_t exp;
        data_t act;
        forever begin
            wait (cmp_act.size() != 0);
            name = cmp_name.pop_front();
            exp  = cmp_exp.pop_front();
            act  = cmp_act.pop_front();
            checks++;
            if (act !== exp) begin
                errors++;
                $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge seq);
        $display("TIMEOUT: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        addr_t a;
        void'($urandom(66315));
        awvalid = '0;
        awaddr  = '0;
        wvalid  = '0;
        wdata   = '0;
        wstrb   = '0;
        bready  = '0;
        arvalid = '0;
        araddr  = '0;
        rready  = '0;
        for (int s = 0; s < NUM_SUBS; s++) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                shadow[s][w] = '0;
            end
        end

        do begin
            @(negedge seq);
            post_check("reset_quiet", '0, data_t'({awready, wready, bvalid, arready, rvalid}));
        end while (reset);
        @(negedge seq);
        post_check("reset_quiet", '0, data_t'({awready, wready, bvalid, arready, rvalid}));
        finish_test("reset_quiet");
        wait_cycles(1);

        for (int m = 0; m < NUM_MGRS; m++) begin
            for (int s = 0; s < NUM_SUBS; s++) begin
                a = word_addr(s, own_word(m));
                for (int r = 0; r < 2; r++) begin
                    name_loop: begin
                        write_txn(m, $sformatf("strobe_rw m%0d s%0d", m, s), a, $urandom,
                                  strb_t'($urandom), 0);
                        read_txn(m, $sformatf("strobe_rw m%0d s%0d", m, s), a, 0);
                    end
                end
            end
        end
        finish_test("strobe_rw");

        write_txn(0, "decode r0", word_addr(0, 16), 32'h1111_aaaa, 4'hf, 0);
        write_txn(0, "decode r1", word_addr(1, 16), 32'h2222_5555, 4'hf, 0);
        read_txn(0, "decode r0", word_addr(0, 16), 0);
        read_txn(0, "decode r1", word_addr(1, 16), 0);
        finish_test("decode");

        // Region 2 and region 0x8000 both fold onto bank 0 if the decode is wrong.
        write_txn(0, "unmapped r2", word_addr(2, 16), 32'hdead_beef, 4'hf, 0);
        read_txn(0, "unmapped r2", word_addr(2, 16), 0);
        read_txn(0, "unmapped alias r2", word_addr(0, 16), 0);
        write_txn(0, "unmapped r8000", word_addr(32'h8000, 16), 32'hbad0_cafe, 4'hf, 0);
        read_txn(0, "unmapped r8000", word_addr(32'h8000, 16), 0);
        read_txn(0, "unmapped alias r8000", word_addr(0, 16), 0);
        finish_test("unmapped");

        fork
            run_mix(0);
            run_mix(1);
        join
        finish_test("contention");

        for (int s = 0; s < NUM_SUBS; s++) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                read_txn(0, $sformatf("sweep s%0d w%0d", s, w), word_addr(s, w), 0);
            end
        end
        finish_test("sweep");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verif/axil_clk_gen.sv
`timescale 1ns/1ps

module axil_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic seq,
    output logic reset
);

    initial begin
        seq = 1'b0;
        forever #(PERIOD_NS / 2) seq = ~seq;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge seq);
        #1 reset = 1'b0; // Released just after the edge, like every other input.
    end

endmodule

// File: hw/axil_xbar_top.sv
`timescale 1ns/1ps

module axil_xbar_top
    import axil_xbar_pkg::*;
#(
    parameter int NUM_MGRS   = 2,
    parameter int NUM_SUBS   = 2,
    parameter int BANK_WORDS = 256
) (
    input  logic                 seq,
    input  logic                 reset,

    input  logic  [NUM_MGRS-1:0] awvalid,
    output logic  [NUM_MGRS-1:0] awready,
    input  addr_t [NUM_MGRS-1:0] awaddr,
    input  logic  [NUM_MGRS-1:0] wvalid,
    output logic  [NUM_MGRS-1:0] wready,
    input  data_t [NUM_MGRS-1:0] wdata,
    input  strb_t [NUM_MGRS-1:0] wstrb,
    output logic  [NUM_MGRS-1:0] bvalid,
    input  logic  [NUM_MGRS-1:0] bready,
    output resp_t [NUM_MGRS-1:0] bresp,

    input  logic  [NUM_MGRS-1:0] arvalid,
    output logic  [NUM_MGRS-1:0] arready,
    input  addr_t [NUM_MGRS-1:0] araddr,
    output logic  [NUM_MGRS-1:0] rvalid,
    input  logic  [NUM_MGRS-1:0] rready,
    output data_t [NUM_MGRS-1:0] rdata,
    output resp_t [NUM_MGRS-1:0] rresp
);

    logic  [NUM_SUBS-1:0] s_awvalid;
    logic  [NUM_SUBS-1:0] s_awready;
    addr_t [NUM_SUBS-1:0] s_awaddr;
    logic  [NUM_SUBS-1:0] s_wvalid;
    logic  [NUM_SUBS-1:0] s_wready;
    data_t [NUM_SUBS-1:0] s_wdata;
    strb_t [NUM_SUBS-1:0] s_wstrb;
    logic  [NUM_SUBS-1:0] s_bvalid;
    logic  [NUM_SUBS-1:0] s_bready;
    resp_t [NUM_SUBS-1:0] s_bresp;

    logic  [NUM_SUBS-1:0] s_arvalid;
    logic  [NUM_SUBS-1:0] s_arready;
    addr_t [NUM_SUBS-1:0] s_araddr;
    logic  [NUM_SUBS-1:0] s_rvalid;
    logic  [NUM_SUBS-1:0] s_rready;
    data_t [NUM_SUBS-1:0] s_rdata;
    resp_t [NUM_SUBS-1:0] s_rresp;

    axil_write_router #(
        .NUM_MGRS (NUM_MGRS),
        .NUM_SUBS (NUM_SUBS)
    ) write_router_i (
        .seq       (seq),
        .reset     (reset),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_awaddr  (s_awaddr),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_bresp   (s_bresp)
    );

    axil_read_router #(
        .NUM_MGRS (NUM_MGRS),
        .NUM_SUBS (NUM_SUBS)
    ) read_router_i (
        .seq       (seq),
        .reset     (reset),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp)
    );

    // One bank per mapped region.
    for (genvar s = 0; s < NUM_SUBS; s++) begin : g_bank
        axil_reg_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) reg_bank_i (
            .seq     (seq),
            .reset   (reset),
            .awvalid (s_awvalid[s]),
            .awready (s_awready[s]),
            .awaddr  (s_awaddr[s]),
            .wvalid  (s_wvalid[s]),
            .wready  (s_wready[s]),
            .wdata   (s_wdata[s]),
            .wstrb   (s_wstrb[s]),
            .bvalid  (s_bvalid[s]),
            .bready  (s_bready[s]),
            .bresp   (s_bresp[s]),
            .arvalid (s_arvalid[s]),
            .arready (s_arready[s]),
            .araddr  (s_araddr[s]),
            .rvalid  (s_rvalid[s]),
            .rready  (s_rready[s]),
            .rdata   (s_rdata[s]),
            .rresp   (s_rresp[s])
        );
    end

endmodule

// File: hw/axil_reg_bank.sv
`timescale 1ns/1ps

module axil_reg_bank
    import axil_xbar_pkg::*;
#(
    parameter int BANK_WORDS = 256
) (
    input  logic  seq,
    input  logic  reset,

    input  logic  awvalid,
    output logic  awready,
    input  addr_t awaddr,
    input  logic  wvalid,
    output logic  wready,
    input  data_t wdata,
    input  strb_t wstrb,
    output logic  bvalid,
    input  logic  bready,
    output resp_t bresp,

    input  logic  arvalid,
    output logic  arready,
    input  addr_t araddr,
    output logic  rvalid,
    input  logic  rready,
    output data_t rdata,
    output resp_t rresp
);

    localparam int IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    data_t            mem [BANK_WORDS];
    logic             wr_go;
    logic             rd_go;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Word index wraps, so every offset in the region aliases into the bank.
    assign wr_idx = IDX_W'((awaddr >> 2) % BANK_WORDS);
    assign rd_idx = IDX_W'((araddr >> 2) % BANK_WORDS);

    assign wr_go   = awvalid && wvalid && !bvalid; // AW and W are taken in the same beat.
    assign awready = wr_go;
    assign wready  = wr_go;
    assign bresp   = RESP_OKAY;

    assign rd_go   = arvalid && !rvalid;
    assign arready = rd_go;
    assign rresp   = RESP_OKAY;

    always_ff @(posedge seq) begin
        if (reset) begin
            bvalid <= 1'b0;
            for (int i = 0; i < BANK_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_go) begin
            bvalid <= 1'b1;
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (rd_go) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

// File: hw/axil_read_router.sv
`timescale 1ns/1ps

module axil_read_router
    import axil_xbar_pkg::*;
#(
    parameter int NUM_MGRS = 2,
    parameter int NUM_SUBS = 2
) (
    input  logic                 seq,
    input  logic                 reset,

    input  logic  [NUM_MGRS-1:0] arvalid,
    output logic  [NUM_MGRS-1:0] arready,
    input  addr_t [NUM_MGRS-1:0] araddr,
    output logic  [NUM_MGRS-1:0] rvalid,
    input  logic  [NUM_MGRS-1:0] rready,
    output data_t [NUM_MGRS-1:0] rdata,
    output resp_t [NUM_MGRS-1:0] rresp,

    output logic  [NUM_SUBS-1:0] s_arvalid,
    input  logic  [NUM_SUBS-1:0] s_arready,
    output addr_t [NUM_SUBS-1:0] s_araddr,
    input  logic  [NUM_SUBS-1:0] s_rvalid,
    output logic  [NUM_SUBS-1:0] s_rready,
    input  data_t [NUM_SUBS-1:0] s_rdata,
    input  resp_t [NUM_SUBS-1:0] s_rresp
);

    localparam int MGR_W = (NUM_MGRS > 1) ? $clog2(NUM_MGRS) : 1;
    localparam int SUB_W = (NUM_SUBS > 1) ? $clog2(NUM_SUBS) : 1;

    logic [NUM_MGRS-1:0][SUB_W-1:0] ar_tgt;
    logic [NUM_MGRS-1:0]            ar_err;
    logic [NUM_MGRS-1:0]            err_go;
    logic [NUM_MGRS-1:0]            err_rvalid;

    lock_state_t                    lock_q [NUM_SUBS];
    logic [NUM_SUBS-1:0][MGR_W-1:0] owner_q;
    logic [NUM_SUBS-1:0][MGR_W-1:0] rr_q;
    logic [NUM_SUBS-1:0]            busy;
    logic [NUM_SUBS-1:0]            gnt_vld;
    logic [NUM_SUBS-1:0][MGR_W-1:0] gnt_idx;

    for (genvar m = 0; m < NUM_MGRS; m++) begin : g_mgr
        axil_addr_decode #(
            .NUM_SUBS (NUM_SUBS)
        ) ar_dec_i (
            .addr    (araddr[m]),
            .sub_idx (ar_tgt[m]),
            .dec_err (ar_err[m])
        );

        assign err_go[m] = arvalid[m] && ar_err[m] && !err_rvalid[m];
    end

    always_comb begin
        int cand;
        gnt_vld = '0;
        gnt_idx = '0;
        for (int s = 0; s < NUM_SUBS; s++) begin
            for (int k = 0; k < NUM_MGRS; k++) begin
                cand = (int'(rr_q[s]) + k) % NUM_MGRS;
                if (!gnt_vld[s] && arvalid[cand] && !ar_err[cand] &&
                    (ar_tgt[cand] == SUB_W'(s))) begin
                    gnt_vld[s] = 1'b1;
                    gnt_idx[s] = MGR_W'(cand);
                end
            end
        end
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            for (int s = 0; s < NUM_SUBS; s++) begin
                lock_q[s]  <= LOCK_IDLE;
                owner_q[s] <= '0;
                rr_q[s]    <= '0;
            end
            err_rvalid <= '0;
        end else begin
            for (int s = 0; s < NUM_SUBS; s++) begin
                if (lock_q[s] == LOCK_IDLE) begin
                    if (gnt_vld[s]) begin
                        lock_q[s]  <= LOCK_BUSY;
                        owner_q[s] <= gnt_idx[s];
                        rr_q[s]    <= (gnt_idx[s] == MGR_W'(NUM_MGRS - 1)) ? '0
                                                                             : gnt_idx[s] + 1'b1;
                    end
                end else if (s_rvalid[s] && s_rready[s]) begin
                    lock_q[s] <= LOCK_IDLE;
                end
            end
            for (int m = 0; m < NUM_MGRS; m++) begin
                if (err_go[m]) begin
                    err_rvalid[m] <= 1'b1; // DECERR goes out the cycle after AR.
                end else if (err_rvalid[m] && rready[m]) begin
                    err_rvalid[m] <= 1'b0;
                end
            end
        end
    end

    for (genvar s = 0; s < NUM_SUBS; s++) begin : g_sub
        assign busy[s]      = (lock_q[s] == LOCK_BUSY);
        assign s_arvalid[s] = busy[s] && arvalid[owner_q[s]];
        assign s_araddr[s]  = araddr[owner_q[s]];
        assign s_rready[s]  = busy[s] && rready[owner_q[s]];
    end

    always_comb begin
        arready = err_go;
        rvalid  = err_rvalid;
        for (int m = 0; m < NUM_MGRS; m++) begin
            rdata[m] = '0; // Unmapped reads return zero data.
            rresp[m] = RESP_DECERR;
        end
        for (int s = 0; s < NUM_SUBS; s++) begin
            if (busy[s]) begin
                arready[owner_q[s]] = arready[owner_q[s]] | s_arready[s];
                rvalid[owner_q[s]]  = rvalid[owner_q[s]] | s_rvalid[s];
                if (s_rvalid[s]) begin
                    rdata[owner_q[s]] = s_rdata[s];
                    rresp[owner_q[s]] = s_rresp[s];
                end
            end
        end
    end

endmodule

// File: hw/axil_write_router.sv
`timescale 1ns/1ps

module axil_write_router
    import axil_xbar_pkg::*;
#(
    parameter int NUM_MGRS = 2,
    parameter int NUM_SUBS = 2
) (
    input  logic                         seq,
    input  logic                         reset,

    input  logic  [NUM_MGRS-1:0]         awvalid,
    output logic  [NUM_MGRS-1:0]         awready,
    input  addr_t [NUM_MGRS-1:0]         awaddr,
    input  logic  [NUM_MGRS-1:0]         wvalid,
    output logic  [NUM_MGRS-1:0]         wready,
    input  data_t [NUM_MGRS-1:0]         wdata,
    input  strb_t [NUM_MGRS-1:0]         wstrb,
    output logic  [NUM_MGRS-1:0]         bvalid,
    input  logic  [NUM_MGRS-1:0]         bready,
    output resp_t [NUM_MGRS-1:0]         bresp,

    output logic  [NUM_SUBS-1:0]         s_awvalid,
    input  logic  [NUM_SUBS-1:0]         s_awready,
    output addr_t [NUM_SUBS-1:0]         s_awaddr,
    output logic  [NUM_SUBS-1:0]         s_wvalid,
    input  logic  [NUM_SUBS-1:0]         s_wready,
    output data_t [NUM_SUBS-1:0]         s_wdata,
    output strb_t [NUM_SUBS-1:0]         s_wstrb,
    input  logic  [NUM_SUBS-1:0]         s_bvalid,
    output logic  [NUM_SUBS-1:0]         s_bready,
    input  resp_t [NUM_SUBS-1:0]         s_bresp
);

    localparam int MGR_W = (NUM_MGRS > 1) ? $clog2(NUM_MGRS) : 1;
    localparam int SUB_W = (NUM_SUBS > 1) ? $clog2(NUM_SUBS) : 1;

    logic [NUM_MGRS-1:0][SUB_W-1:0] aw_tgt;
    logic [NUM_MGRS-1:0]            aw_err;
    logic [NUM_MGRS-1:0]            err_go;
    logic [NUM_MGRS-1:0]            err_bvalid;

    lock_state_t                    lock_q [NUM_SUBS];
    logic [NUM_SUBS-1:0][MGR_W-1:0] owner_q;
    logic [NUM_SUBS-1:0][MGR_W-1:0] rr_q;
    logic [NUM_SUBS-1:0]            busy;
    logic [NUM_SUBS-1:0]            gnt_vld;
    logic [NUM_SUBS-1:0][MGR_W-1:0] gnt_idx;

    for (genvar m = 0; m < NUM_MGRS; m++) begin : g_mgr
        axil_addr_decode #(
            .NUM_SUBS (NUM_SUBS)
        ) aw_dec_i (
            .addr    (awaddr[m]),
            .sub_idx (aw_tgt[m]),
            .dec_err (aw_err[m])
        );

        // The error responder takes AW and W in one beat, like a bank does.
        assign err_go[m] = awvalid[m] && wvalid[m] && aw_err[m] && !err_bvalid[m];
    end

    always_comb begin
        int cand;
        gnt_vld = '0;
        gnt_idx = '0;
        for (int s = 0; s < NUM_SUBS; s++) begin
            for (int k = 0; k < NUM_MGRS; k++) begin
                cand = (int'(rr_q[s]) + k) % NUM_MGRS; // Search starts after the last owner.
                if (!gnt_vld[s] && awvalid[cand] && !aw_err[cand] &&
                    (aw_tgt[cand] == SUB_W'(s))) begin
                    gnt_vld[s] = 1'b1;
                    gnt_idx[s] = MGR_W'(cand);
                end
            end
        end
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            for (int s = 0; s < NUM_SUBS; s++) begin
                lock_q[s]  <= LOCK_IDLE;
                owner_q[s] <= '0;
                rr_q[s]    <= '0;
            end
            err_bvalid <= '0;
        end else begin
            for (int s = 0; s < NUM_SUBS; s++) begin
                if (lock_q[s] == LOCK_IDLE) begin
                    if (gnt_vld[s]) begin
                        lock_q[s]  <= LOCK_BUSY;
                        owner_q[s] <= gnt_idx[s];
                        rr_q[s]    <= (gnt_idx[s] == MGR_W'(NUM_MGRS - 1)) ? '0
                                                                             : gnt_idx[s] + 1'b1;
                    end
                end else if (s_bvalid[s] && s_bready[s]) begin
                    lock_q[s] <= LOCK_IDLE; // The owner has taken its response.
                end
            end
            for (int m = 0; m < NUM_MGRS; m++) begin
                if (err_go[m]) begin
                    err_bvalid[m] <= 1'b1;
                end else if (err_bvalid[m] && bready[m]) begin
                    err_bvalid[m] <= 1'b0;
                end
            end
        end
    end

    for (genvar s = 0; s < NUM_SUBS; s++) begin : g_sub
        assign busy[s]      = (lock_q[s] == LOCK_BUSY);
        assign s_awvalid[s] = busy[s] && awvalid[owner_q[s]];
        assign s_awaddr[s]  = awaddr[owner_q[s]];
        assign s_wvalid[s]  = busy[s] && wvalid[owner_q[s]];
        assign s_wdata[s]   = wdata[owner_q[s]];
        assign s_wstrb[s]   = wstrb[owner_q[s]];
        assign s_bready[s]  = busy[s] && bready[owner_q[s]];
    end

    // A manager owns at most one write lock, so the OR never merges two banks.
    always_comb begin
        awready = err_go;
        wready  = err_go;
        bvalid  = err_bvalid;
        for (int m = 0; m < NUM_MGRS; m++) begin
            bresp[m] = RESP_DECERR;
        end
        for (int s = 0; s < NUM_SUBS; s++) begin
            if (busy[s]) begin
                awready[owner_q[s]] = awready[owner_q[s]] | s_awready[s];
                wready[owner_q[s]]  = wready[owner_q[s]] | s_wready[s];
                bvalid[owner_q[s]]  = bvalid[owner_q[s]] | s_bvalid[s];
                if (s_bvalid[s]) begin
                    bresp[owner_q[s]] = s_bresp[s];
                end
            end
        end
    end

endmodule

// File: hw/axil_addr_decode.sv
`timescale 1ns/1ps

module axil_addr_decode
    import axil_xbar_pkg::*;
#(
    parameter int NUM_SUBS = 2,
    localparam int SUB_W = (NUM_SUBS > 1) ? $clog2(NUM_SUBS) : 1
) (
    input  addr_t            addr,
    output logic [SUB_W-1:0] sub_idx,
    output logic             dec_err
);

    logic [$bits(addr_t)-REGION_LSB-1:0] region;

    assign region  = addr[$bits(addr_t)-1:REGION_LSB];
    assign dec_err = (region >= NUM_SUBS); // Regions past the last bank are unmapped.
    assign sub_idx = region[SUB_W-1:0];

endmodule

// File: hw/axil_xbar_pkg.sv
package axil_xbar_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // Address bits from here up select the subordinate region.
    localparam int REGION_LSB = 16;

    typedef enum logic {
        LOCK_IDLE,
        LOCK_BUSY
    } lock_state_t;

endpackage
